/* exec_stage.f */
logic/cpu_pkg.sv
logic/alu.sv
logic/div_fsm.sv
logic/div_counter.sv
logic/div_datapath.sv
logic/hilo_reg.sv
logic/exec_stage.sv
verification/exec_stage_assertions.sv
verification/exec_stage_checker.sv
verification/exec_stage_tb.sv

/* logic/alu.sv */
`default_nettype none

module alu (
    input  wire cpu_pkg::oper_t  oper_i,
    input  wire cpu_pkg::word_t  reg1_i,
    input  wire cpu_pkg::word_t  reg2_i,
    input  wire cpu_pkg::word_t  hi_i,
    input  wire cpu_pkg::word_t  lo_i,
    input  wire                  wreg_write_i,
    output cpu_pkg::word_t       data_o,
    output logic                 wreg_write_o,
    output logic                 hilo_we_o,
    output cpu_pkg::dword_t      hilo_o,
    output logic                 hi_we_o,
    output logic                 lo_we_o
);
    import cpu_pkg::*;

    word_t  add_res;
    word_t  sub_res;
    logic   signed_lt;
    logic   unsigned_lt;
    logic   mul_signed;
    logic   prod_neg;
    word_t  mag1;
    word_t  mag2;
    dword_t prod_mag;
    dword_t prod;

    assign add_res = reg1_i + reg2_i;
    assign sub_res = reg1_i - reg2_i;

    // sign differs: the negative one is smaller
    assign signed_lt   = (reg1_i[31] != reg2_i[31]) ? reg1_i[31] : sub_res[31];
    assign unsigned_lt = (reg1_i < reg2_i);

    // sign-magnitude multiply, MULTU skips the sign handling
    assign mul_signed = (oper_i != OP_MULTU);
    assign prod_neg   = mul_signed && (reg1_i[31] ^ reg2_i[31]);
    assign mag1       = (mul_signed && reg1_i[31]) ? -reg1_i : reg1_i;
    assign mag2       = (mul_signed && reg2_i[31]) ? -reg2_i : reg2_i;
    assign prod_mag   = dword_t'(mag1) * dword_t'(mag2);
    assign prod       = prod_neg ? -prod_mag : prod_mag;

    always_comb begin
        data_o       = ZERO_WORD;
        wreg_write_o = wreg_write_i;
        hilo_o       = {hi_i, lo_i};
        hi_we_o      = 1'b0;
        lo_we_o      = 1'b0;
        case (oper_i)
            OP_AND:  data_o = reg1_i & reg2_i;
            OP_OR:   data_o = reg1_i | reg2_i;
            OP_XOR:  data_o = reg1_i ^ reg2_i;
            OP_NOR:  data_o = ~(reg1_i | reg2_i);
            OP_SLL:  data_o = reg2_i << reg1_i[4:0];
            OP_SRL:  data_o = reg2_i >> reg1_i[4:0];
            OP_SRA:  data_o = $signed(reg2_i) >>> reg1_i[4:0];
            OP_LUI:  data_o = {reg2_i[15:0], 16'h0000};
            OP_ADD:  data_o = add_res;
            OP_SUB:  data_o = sub_res;
            OP_SLT:  data_o = {{31{1'b0}}, signed_lt};
            OP_SLTU: data_o = {{31{1'b0}}, unsigned_lt};
            OP_MOVN: begin
                data_o       = reg1_i;
                wreg_write_o = wreg_write_i && (reg2_i != ZERO_WORD);
            end
            OP_MOVZ: begin
                data_o       = reg1_i;
                wreg_write_o = wreg_write_i && (reg2_i == ZERO_WORD);
            end
            OP_MUL:  data_o = prod[31:0];
            OP_MULT, OP_MULTU: begin
                hilo_o  = prod;
                hi_we_o = 1'b1;
                lo_we_o = 1'b1;
            end
            OP_MTHI: begin
                hilo_o[63:32] = reg1_i;
                hi_we_o       = 1'b1;
            end
            OP_MTLO: begin
                hilo_o[31:0] = reg1_i;
                lo_we_o      = 1'b1;
            end
            OP_MFHI: data_o = hi_i;
            OP_MFLO: data_o = lo_i;
            default: begin
            end
        endcase
        hilo_we_o = hi_we_o || lo_we_o;
        // HI/LO writers and divides never touch the register file
        if (hilo_we_o || oper_i == OP_DIV || oper_i == OP_DIVU) begin
            wreg_write_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;

    // decoded operations handled by the execute stage
    typedef enum logic [4:0] {
        OP_NOP,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_MOVN,
        OP_MOVZ,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_MTHI,
        OP_MTLO,
        OP_MFHI,
        OP_MFLO,
        OP_DIV,
        OP_DIVU
    } oper_t;

    localparam word_t ZERO_WORD = '0;

    // one quotient bit per iteration
    localparam int DIV_ITERS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_ITERS);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIXUP
    } div_state_t;

endpackage

`default_nettype wire

/* logic/div_counter.sv */
`default_nettype none

module div_counter (
    input  wire  clk_i,
    input  wire  rst_n_i,
    input  wire  load_i,
    input  wire  en_i,
    output logic last_o
);
    import cpu_pkg::*;

    logic [DIV_CNT_W-1:0] cnt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cnt <= '0;
        end else if (load_i) begin
            cnt <= DIV_CNT_W'(DIV_ITERS - 1);
        end else if (en_i && cnt != '0) begin
            // hold at zero, no wrap
            cnt <= cnt - 1'b1;
        end
    end

    assign last_o = (cnt == '0);

endmodule

`default_nettype wire

/* logic/div_datapath.sv */
`default_nettype none

module div_datapath (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  wire                 load_i,
    input  wire                 step_i,
    input  wire                 fixup_i,
    input  wire                 signed_i,
    input  wire cpu_pkg::word_t dividend_i,
    input  wire cpu_pkg::word_t divisor_i,
    output cpu_pkg::word_t      quotient_o,
    output cpu_pkg::word_t      remainder_o
);
    import cpu_pkg::*;

    word_t       quot;
    word_t       rem;
    word_t       dvs;
    logic        q_neg;
    logic        r_neg;
    logic [32:0] partial;
    logic [32:0] diff;

    // next dividend bit enters the partial remainder
    assign partial = {rem, quot[31]};
    assign diff    = partial - {1'b0, dvs};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q_neg <= 1'b0;
            r_neg <= 1'b0;
        end else if (load_i) begin
            q_neg <= signed_i && (dividend_i[31] ^ divisor_i[31]);
            r_neg <= signed_i && dividend_i[31];
        end
    end

    // quot starts as the dividend and fills with quotient bits from the right
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            quot <= (signed_i && dividend_i[31]) ? -dividend_i : dividend_i;
            dvs  <= (signed_i && divisor_i[31]) ? -divisor_i : divisor_i;
            rem  <= ZERO_WORD;
        end else if (step_i) begin
            if (!diff[32]) begin
                rem  <= diff[31:0];
                quot <= {quot[30:0], 1'b1};
            end else begin
                // restore, divisor does not fit
                rem  <= partial[31:0];
                quot <= {quot[30:0], 1'b0};
            end
        end
    end

    // remainder follows the dividend sign
    assign quotient_o  = (fixup_i && q_neg) ? -quot : quot;
    assign remainder_o = (fixup_i && r_neg) ? -rem : rem;

endmodule

`default_nettype wire

/* logic/div_fsm.sv */
`default_nettype none

module div_fsm (
    input  wire  clk_i,
    input  wire  rst_n_i,
    input  wire  start_i,
    input  wire  last_i,
    output logic load_o,
    output logic step_o,
    output logic fixup_o,
    output logic busy_o,
    output logic done_o
);
    import cpu_pkg::*;

    div_state_t state;
    div_state_t state_nxt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= DIV_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            DIV_IDLE: begin
                if (start_i) begin
                    state_nxt = DIV_RUN;
                end
            end
            DIV_RUN: begin
                // counter flags the final quotient bit
                if (last_i) begin
                    state_nxt = DIV_FIXUP;
                end
            end
            DIV_FIXUP: state_nxt = DIV_IDLE;
            default:   state_nxt = DIV_IDLE;
        endcase
    end

    // operands are captured at the strobe edge
    assign load_o  = (state == DIV_IDLE) && start_i;
    assign step_o  = (state == DIV_RUN);
    assign fixup_o = (state == DIV_FIXUP);
    assign busy_o  = (state != DIV_IDLE);

    // signed results are valid during the fixup cycle
    assign done_o  = (state == DIV_FIXUP);

endmodule

`default_nettype wire

/* logic/exec_stage.sv */
`default_nettype none

module exec_stage (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     valid_i,
    input  wire cpu_pkg::oper_t     oper_i,
    input  wire cpu_pkg::word_t     reg1_i,
    input  wire cpu_pkg::word_t     reg2_i,
    input  wire                     wreg_write_i,
    input  wire cpu_pkg::reg_addr_t wreg_addr_i,
    output logic                    valid_o,
    output logic                    wreg_write_o,
    output cpu_pkg::reg_addr_t      wreg_addr_o,
    output cpu_pkg::word_t          wreg_data_o,
    output cpu_pkg::word_t          hi_o,
    output cpu_pkg::word_t          lo_o,
    output logic                    stallreq_o
);
    import cpu_pkg::*;

    logic   accept;
    logic   is_div;
    logic   alu_go;
    logic   div_start;
    word_t  alu_data;
    logic   alu_wreg_write;
    logic   alu_hilo_we;
    dword_t alu_hilo;
    logic   alu_hi_we;
    logic   alu_lo_we;
    logic   div_load;
    logic   div_step;
    logic   div_fixup;
    logic   div_busy;
    logic   div_done;
    logic   div_last;
    word_t  div_quot;
    word_t  div_rem;
    logic   hi_we;
    logic   lo_we;
    word_t  hi_wdata;
    word_t  lo_wdata;

    // strobes during a divide are dropped
    assign accept    = valid_i && !stallreq_o;
    assign is_div    = (oper_i == OP_DIV) || (oper_i == OP_DIVU);
    assign div_start = accept && is_div;
    assign alu_go    = accept && !is_div;

    alu u_alu (
        .oper_i       (oper_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .hi_i         (hi_o),
        .lo_i         (lo_o),
        .wreg_write_i (wreg_write_i),
        .data_o       (alu_data),
        .wreg_write_o (alu_wreg_write),
        .hilo_we_o    (alu_hilo_we),
        .hilo_o       (alu_hilo),
        .hi_we_o      (alu_hi_we),
        .lo_we_o      (alu_lo_we)
    );

    div_fsm u_div_fsm (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (div_start),
        .last_i  (div_last),
        .load_o  (div_load),
        .step_o  (div_step),
        .fixup_o (div_fixup),
        .busy_o  (div_busy),
        .done_o  (div_done)
    );

    div_counter u_div_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .load_i  (div_load),
        .en_i    (div_step),
        .last_o  (div_last)
    );

    div_datapath u_div_datapath (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_i      (div_load),
        .step_i      (div_step),
        .fixup_i     (div_fixup),
        .signed_i    (oper_i == OP_DIV),
        .dividend_i  (reg1_i),
        .divisor_i   (reg2_i),
        .quotient_o  (div_quot),
        .remainder_o (div_rem)
    );

    // divider wins on done, HI gets the remainder
    assign hi_we    = div_done || (alu_go && alu_hilo_we && alu_hi_we);
    assign lo_we    = div_done || (alu_go && alu_hilo_we && alu_lo_we);
    assign hi_wdata = div_done ? div_rem : alu_hilo[63:32];
    assign lo_wdata = div_done ? div_quot : alu_hilo[31:0];

    hilo_reg u_hilo_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .hi_we_i (hi_we),
        .lo_we_i (lo_we),
        .hi_i    (hi_wdata),
        .lo_i    (lo_wdata),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o      <= 1'b0;
            wreg_write_o <= 1'b0;
        end else begin
            valid_o      <= alu_go || div_done;
            wreg_write_o <= alu_go && alu_wreg_write;
        end
    end

    always_ff @(posedge clk_i) begin
        if (alu_go) begin
            wreg_addr_o <= wreg_addr_i;
            wreg_data_o <= alu_data;
        end
    end

    assign stallreq_o = div_busy;

endmodule

`default_nettype wire

/* logic/hilo_reg.sv */
`default_nettype none

module hilo_reg (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    input  wire                 hi_we_i,
    input  wire                 lo_we_i,
    input  wire cpu_pkg::word_t hi_i,
    input  wire cpu_pkg::word_t lo_i,
    output cpu_pkg::word_t      hi_o,
    output cpu_pkg::word_t      lo_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hi_o <= '0;
        end else if (hi_we_i) begin
            hi_o <= hi_i;
        end
    end

    // halves written on their own for MTHI and MTLO
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lo_o <= '0;
        end else if (lo_we_i) begin
            lo_o <= lo_i;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the exec_stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f exec_stage.f \
    --top-module exec_stage_tb \
    -o exec_stage_sim

./obj_dir/exec_stage_sim | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verification/exec_stage_assertions.sv */
`default_nettype none

module exec_stage_assertions (
    input wire                     clk_i,
    input wire                     rst_n_i,
    input wire                     strobe_i,
    input wire                     result_i,
    input wire                     stall_i,
    input wire                     div_done_i,
    input wire cpu_pkg::div_state_t div_state_i
);
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    // no new operation while the divider holds the stage
    no_strobe_in_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> !strobe_i)
        else $error("strobe seen while stall request is high");

    valid_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_i |=> !result_i)
        else $error("valid_o held high for more than one cycle");

    // done closes a run of one step per quotient bit
    done_only_in_fixup: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        div_done_i |-> (div_state_i == DIV_FIXUP)
            && ($past(div_state_i, DIV_ITERS) == DIV_RUN)
            && ($past(div_state_i, DIV_ITERS + 1) == DIV_IDLE))
        else $error("divider done outside fixup or after a run of the wrong length");

endmodule

`default_nettype wire

/* verification/exec_stage_checker.sv */
`default_nettype none

module exec_stage_checker (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     dut_strobe_i,
    input  wire                     dut_valid_i,
    input  wire                     dut_write_i,
    input  wire cpu_pkg::reg_addr_t dut_addr_i,
    input  wire cpu_pkg::word_t     dut_data_i,
    input  wire cpu_pkg::word_t     dut_hi_i,
    input  wire cpu_pkg::word_t     dut_lo_i,
    input  wire                     dut_stall_i,
    input  wire                     exp_write_i,
    input  wire cpu_pkg::reg_addr_t exp_addr_i,
    input  wire cpu_pkg::word_t     exp_data_i,
    input  wire cpu_pkg::word_t     exp_hi_i,
    input  wire cpu_pkg::word_t     exp_lo_i,
    input  wire                     exp_div_i,
    output int                      error_count_o,
    output int                      result_count_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    // load, one run cycle per quotient bit, fixup and the output register
    localparam int DIV_LATENCY = DIV_ITERS + 2;

    int   errors = 0;
    int   results = 0;
    int   stall_cycles = 0;
    int   latency = 0;
    int   exp_latency;
    logic reset_checked = 1'b0;

    assign error_count_o  = errors;
    assign result_count_o = results;
    assign exp_latency    = exp_div_i ? DIV_LATENCY : 1;

    task automatic report(input string msg);
        errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endtask

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            report($sformatf("%s got %08h, expected %08h", what, got, exp));
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            reset_checked <= 1'b0;
            stall_cycles  <= 0;
            latency       <= 0;
        end else begin
            // first sample after reset release
            if (!reset_checked) begin
                reset_checked <= 1'b1;
                if (dut_valid_i !== 1'b0 || dut_write_i !== 1'b0 || dut_stall_i !== 1'b0) begin
                    report("control outputs not low after reset");
                end
                compare_word("hi after reset", dut_hi_i, 32'h0);
                compare_word("lo after reset", dut_lo_i, 32'h0);
            end
            if (dut_valid_i) begin
                results++;
                if (latency != exp_latency) begin
                    report($sformatf("result came %0d cycles after the strobe, expected %0d",
                        latency, exp_latency));
                end
                if (dut_write_i !== exp_write_i) begin
                    report($sformatf("write enable got %b, expected %b", dut_write_i,
                        exp_write_i));
                end
                if (exp_write_i) begin
                    if (dut_addr_i !== exp_addr_i) begin
                        report($sformatf("write address got %0d, expected %0d", dut_addr_i,
                            exp_addr_i));
                    end
                    compare_word("write data", dut_data_i, exp_data_i);
                end
                compare_word("hi", dut_hi_i, exp_hi_i);
                compare_word("lo", dut_lo_i, exp_lo_i);
                // one stall cycle per iteration plus fixup
                if (exp_div_i && stall_cycles != DIV_ITERS + 1) begin
                    report($sformatf("divide stalled %0d cycles, expected %0d", stall_cycles,
                        DIV_ITERS + 1));
                end
                if (!exp_div_i && stall_cycles != 0) begin
                    report("stall request raised for a single-cycle operation");
                end
                if (dut_stall_i) begin
                    report("stall request still high with the result");
                end
                stall_cycles <= 0;
                latency      <= 0;
            end else if (dut_stall_i) begin
                stall_cycles <= stall_cycles + 1;
            end
            if (dut_strobe_i) begin
                latency <= 1;
            end else if (!dut_valid_i && latency != 0) begin
                latency <= latency + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/exec_stage_tb.sv */
`default_nettype none

module exec_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam time CLK_PERIOD = 40ns;
    localparam int  NUM_ROWS   = 30;

    typedef struct {
        oper_t     oper;
        word_t     reg1;
        word_t     reg2;
        logic      write;
        reg_addr_t addr;
        logic      exp_write;
        word_t     exp_data;
        word_t     exp_hi;
        word_t     exp_lo;
    } row_t;

    row_t table_rows [NUM_ROWS];

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      valid_i;
    oper_t     oper_i;
    word_t     reg1_i;
    word_t     reg2_i;
    logic      wreg_write_i;
    reg_addr_t wreg_addr_i;
    logic      valid_o;
    logic      wreg_write_o;
    reg_addr_t wreg_addr_o;
    word_t     wreg_data_o;
    word_t     hi_o;
    word_t     lo_o;
    logic      stallreq_o;

    logic      exp_write;
    reg_addr_t exp_addr;
    word_t     exp_data;
    word_t     exp_hi;
    word_t     exp_lo;
    logic      exp_div;
    int        error_count;
    int        result_count;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    exec_stage u_dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .oper_i       (oper_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .wreg_write_i (wreg_write_i),
        .wreg_addr_i  (wreg_addr_i),
        .valid_o      (valid_o),
        .wreg_write_o (wreg_write_o),
        .wreg_addr_o  (wreg_addr_o),
        .wreg_data_o  (wreg_data_o),
        .hi_o         (hi_o),
        .lo_o         (lo_o),
        .stallreq_o   (stallreq_o)
    );

    exec_stage_checker u_checker (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .dut_strobe_i   (valid_i),
        .dut_valid_i    (valid_o),
        .dut_write_i    (wreg_write_o),
        .dut_addr_i     (wreg_addr_o),
        .dut_data_i     (wreg_data_o),
        .dut_hi_i       (hi_o),
        .dut_lo_i       (lo_o),
        .dut_stall_i    (stallreq_o),
        .exp_write_i    (exp_write),
        .exp_addr_i     (exp_addr),
        .exp_data_i     (exp_data),
        .exp_hi_i       (exp_hi),
        .exp_lo_i       (exp_lo),
        .exp_div_i      (exp_div),
        .error_count_o  (error_count),
        .result_count_o (result_count)
    );

    bind exec_stage exec_stage_assertions u_assertions (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .strobe_i    (valid_i),
        .result_i    (valid_o),
        .stall_i     (stallreq_o),
        .div_done_i  (div_done),
        .div_state_i (u_div_fsm.state)
    );

    // HI/LO columns carry the running state
    task automatic fill_table();
        table_rows[0]  = '{OP_AND,   32'hF0F01234, 32'h0FF0FF00, 1, 5'd1, 1, 32'h00F01200, 0, 0};
        table_rows[1]  = '{OP_OR,    32'hF0F01234, 32'h0FF0FF00, 1, 5'd2, 1, 32'hFFF0FF34, 0, 0};
        table_rows[2]  = '{OP_XOR,   32'hF0F01234, 32'h0FF0FF00, 1, 5'd3, 1, 32'hFF00ED34, 0, 0};
        table_rows[3]  = '{OP_NOR,   32'h000000FF, 32'h0000FF00, 1, 5'd4, 1, 32'hFFFF0000, 0, 0};
        table_rows[4]  = '{OP_SLL,   32'h00000004, 32'h000000F1, 1, 5'd5, 1, 32'h00000F10, 0, 0};
        table_rows[5]  = '{OP_SRL,   32'h00000008, 32'h80000000, 1, 5'd6, 1, 32'h00800000, 0, 0};
        table_rows[6]  = '{OP_SRA,   32'h00000008, 32'h80000000, 1, 5'd7, 1, 32'hFF800000, 0, 0};
        table_rows[7]  = '{OP_LUI,   32'h00000000, 32'h0000ABCD, 1, 5'd8, 1, 32'hABCD0000, 0, 0};
        table_rows[8]  = '{OP_ADD,   32'h7FFFFFFF, 32'h00000001, 1, 5'd9, 1, 32'h80000000, 0, 0};
        table_rows[9]  = '{OP_SUB,   32'h00000005, 32'h00000007, 1, 5'd10, 1, 32'hFFFFFFFE, 0, 0};
        table_rows[10] = '{OP_SLT,   32'hFFFFFFFF, 32'h00000001, 1, 5'd11, 1, 32'h00000001, 0, 0};
        table_rows[11] = '{OP_SLTU,  32'hFFFFFFFF, 32'h00000001, 1, 5'd12, 1, 32'h00000000, 0, 0};
        table_rows[12] = '{OP_MOVN,  32'h12345678, 32'h00000001, 1, 5'd13, 1, 32'h12345678, 0, 0};
        table_rows[13] = '{OP_MOVN,  32'h87654321, 32'h00000000, 1, 5'd14, 0, 32'h0, 0, 0};
        table_rows[14] = '{OP_MOVZ,  32'hCAFE0001, 32'h00000000, 1, 5'd15, 1, 32'hCAFE0001, 0, 0};
        table_rows[15] = '{OP_MUL,   32'hFFFFFFFD, 32'h00000007, 1, 5'd16, 1, 32'hFFFFFFEB, 0, 0};
        table_rows[16] = '{OP_MULT,  32'hFFFFFFFD, 32'h00000007, 0, 5'd0, 0, 32'h0,
                           32'hFFFFFFFF, 32'hFFFFFFEB};
        table_rows[17] = '{OP_MULTU, 32'hFFFFFFFD, 32'h00000007, 0, 5'd0, 0, 32'h0,
                           32'h00000006, 32'hFFFFFFEB};
        table_rows[18] = '{OP_MTHI,  32'h11112222, 32'h0, 0, 5'd0, 0, 32'h0,
                           32'h11112222, 32'hFFFFFFEB};
        table_rows[19] = '{OP_MTLO,  32'h33334444, 32'h0, 0, 5'd0, 0, 32'h0,
                           32'h11112222, 32'h33334444};
        table_rows[20] = '{OP_MFHI,  32'h0, 32'h0, 1, 5'd17, 1, 32'h11112222,
                           32'h11112222, 32'h33334444};
        table_rows[21] = '{OP_MFLO,  32'h0, 32'h0, 1, 5'd18, 1, 32'h33334444,
                           32'h11112222, 32'h33334444};
        // 100 / 7 with every sign combination, then divide by zero
        table_rows[22] = '{OP_DIVU,  32'h00000064, 32'h00000007, 0, 5'd0, 0, 32'h0,
                           32'h00000002, 32'h0000000E};
        table_rows[23] = '{OP_DIV,   32'hFFFFFF9C, 32'h00000007, 0, 5'd0, 0, 32'h0,
                           32'hFFFFFFFE, 32'hFFFFFFF2};
        table_rows[24] = '{OP_DIV,   32'h00000064, 32'hFFFFFFF9, 0, 5'd0, 0, 32'h0,
                           32'h00000002, 32'hFFFFFFF2};
        table_rows[25] = '{OP_DIV,   32'hFFFFFF9C, 32'hFFFFFFF9, 0, 5'd0, 0, 32'h0,
                           32'hFFFFFFFE, 32'h0000000E};
        table_rows[26] = '{OP_DIVU,  32'h00000005, 32'h00000000, 0, 5'd0, 0, 32'h0,
                           32'h00000005, 32'hFFFFFFFF};
        table_rows[27] = '{OP_DIV,   32'hFFFFFFFB, 32'h00000000, 0, 5'd0, 0, 32'h0,
                           32'hFFFFFFFB, 32'h00000001};
        table_rows[28] = '{OP_MFLO,  32'h0, 32'h0, 1, 5'd19, 1, 32'h00000001,
                           32'hFFFFFFFB, 32'h00000001};
        table_rows[29] = '{OP_MOVZ,  32'h0BADF00D, 32'h00000002, 1, 5'd20, 0, 32'h0,
                           32'hFFFFFFFB, 32'h00000001};
    endtask

    initial begin
        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        oper_i       = OP_NOP;
        reg1_i       = '0;
        reg2_i       = '0;
        wreg_write_i = 1'b0;
        wreg_addr_i  = '0;
        exp_write    = 1'b0;
        exp_addr     = '0;
        exp_data     = '0;
        exp_hi       = '0;
        exp_lo       = '0;
        exp_div      = 1'b0;
        fill_table();
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (2) @(posedge clk_i);
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk_i);
            valid_i      <= 1'b1;
            oper_i       <= table_rows[i].oper;
            reg1_i       <= table_rows[i].reg1;
            reg2_i       <= table_rows[i].reg2;
            wreg_write_i <= table_rows[i].write;
            wreg_addr_i  <= table_rows[i].addr;
            exp_write    <= table_rows[i].exp_write;
            exp_addr     <= table_rows[i].addr;
            exp_data     <= table_rows[i].exp_data;
            exp_hi       <= table_rows[i].exp_hi;
            exp_lo       <= table_rows[i].exp_lo;
            exp_div      <= (table_rows[i].oper == OP_DIV) || (table_rows[i].oper == OP_DIVU);
            @(posedge clk_i);
            valid_i <= 1'b0;
            do begin
                @(posedge clk_i);
            end while (!valid_o);
        end
        repeat (2) @(posedge clk_i);
        $display("errors: %0d, results: %0d of %0d", error_count, result_count, NUM_ROWS);
        if (error_count == 0 && result_count == NUM_ROWS) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // every row finishes well inside 40 cycles
    initial begin
        #(NUM_ROWS * 40 * CLK_PERIOD + 20 * CLK_PERIOD);
        $display("timeout: the DUT stopped returning results, run aborted");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
